/* logic/upm_pkg.sv */
/*
 * upm package: widths, typedefs, chain structs and window FSM states
 */
`default_nettype none

package upm_pkg;

	// --------------------
	// widths and sizes
	// --------------------
	localparam int WIN_W   = 16;  // window counter
	localparam int CNT_W   = 12;  // per oscillator, small so long windows overflow
	localparam int NUM_CBB = 16;
	localparam int ADDR_W  = 4;
	localparam int DIV_W   = 3;
	localparam int PER_W   = 8;   // max period (6+15)*8 = 168 fits
	localparam int CHAIN_W = 40;  // scan register length

	// base tick periods of the cbb oscillators, in func clk cycles
	localparam int OSC0_BASE = 4;
	localparam int OSC1_BASE = 6;

	// padding on top of the result word
	localparam int RES_PAD_W = CHAIN_W - 2*CNT_W - 4;

	// --------------------
	// scalar types
	// --------------------
	typedef logic [WIN_W-1:0]   win_t;
	typedef logic [CNT_W-1:0]   osc_cnt_t;
	typedef logic [ADDR_W-1:0]  cbb_addr_t;
	typedef logic [DIV_W-1:0]   clk_div_t;
	typedef logic [NUM_CBB-1:0] pwr_mask_t;
	typedef logic [PER_W-1:0]   per_t;     // oscillator period

	// configuration, shifted in LSB first, run bit ends up at bit 0
	typedef struct packed {
		win_t      window;
		pwr_mask_t pwr_en;
		clk_div_t  div;
		cbb_addr_t addr;
		logic      run;
	} upm_cfg_t;

	// result word, loaded by capture
	typedef struct packed {
		logic [RES_PAD_W-1:0] pad;
		logic                 done;
		logic                 pwr_err;
		logic [1:0]           ovf;     // bit k for oscillator k
		osc_cnt_t             cnt1;
		osc_cnt_t             cnt0;
	} upm_result_t;

	// measurement window FSM
	typedef enum logic [1:0] {
		WIN_IDLE  = 2'd0,
		WIN_COUNT = 2'd1,
		WIN_DONE  = 2'd2
	} upm_win_state_e;

endpackage : upm_pkg

`default_nettype wire

/* logic/upm_cfg_chain.sv */
/*
 * upm config chain: 40-bit scan register with capture/shift/update strobes,
 * holds the configuration and fires start on an update with run set
 */
`default_nettype none

module upm_cfg_chain import upm_pkg::*; (
	input  wire logic        dfx_upm_func_clk_i,
	input  wire logic        arst_n_i,
	input  wire logic        sel_i,
	input  wire logic        capture_i,
	input  wire logic        shift_i,
	input  wire logic        update_i,
	input  wire logic        si_i,
	input  wire upm_result_t result_i,
	output      logic        so_o,
	output      upm_cfg_t    cfg_o,
	output      logic        start_o
);

	logic [CHAIN_W-1:0] sr_q;       // scan register
	upm_cfg_t           cfg_q;      // held configuration
	logic               start_q;

	// strobe decode with capture > shift > update
	logic do_capture;
	logic do_shift;
	logic do_update;

	assign do_capture = sel_i & capture_i;
	assign do_shift   = sel_i & shift_i & ~capture_i;
	assign do_update  = sel_i & update_i & ~capture_i & ~shift_i;

	// --------------------
	// scan register
	// --------------------
	always_ff @(posedge dfx_upm_func_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sr_q <= '0;
		end else if (do_capture) begin
			sr_q <= result_i;                  // result word parallel load
		end else if (do_shift) begin
			sr_q <= {si_i, sr_q[CHAIN_W-1:1]}; // toward lsb with si entering at msb
		end
	end

	assign so_o = sr_q[0];

	// --------------------
	// held config + start
	// --------------------
	always_ff @(posedge dfx_upm_func_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cfg_q   <= '0;
			start_q <= 1'b0;
		end else begin
			start_q <= do_update & sr_q[0];    // run bit sits at lsb
			if (do_update) begin
				cfg_q <= upm_cfg_t'(sr_q);
			end
		end
	end

	// start follows the update by one cycle when config is already in place
	assign start_o = start_q;
	assign cfg_o   = cfg_q;

	// chain protocol allows a single strobe per cycle
	a_one_strobe: assert property (@(posedge dfx_upm_func_clk_i) disable iff (!arst_n_i)
		sel_i |-> $onehot0({capture_i, shift_i, update_i}))
		else $error("upm chain: overlapping capture/shift/update strobes");

endmodule : upm_cfg_chain

`default_nettype wire

/* logic/upm_window_ctrl.sv */
/*
 * upm window control: runs one measurement window of window cycles
 * and holds done until the next start
 */
`default_nettype none

module upm_window_ctrl import upm_pkg::*; (
	input  wire logic dfx_upm_func_clk_i,
	input  wire logic arst_n_i,
	input  wire logic start_i,
	input  wire win_t window_i,
	output      logic count_en_o,
	output      logic active_o,
	output      logic done_o
);

	upm_win_state_e state_q, state_d;
	win_t           remain_q, remain_d;    // cycles left in WIN_COUNT

	// --------------------
	// next state
	// --------------------
	always_comb begin
		state_d  = state_q;
		remain_d = remain_q;
		if (start_i) begin
			// restart from any state and run a zero window for one cycle
			state_d  = WIN_COUNT;
			remain_d = (window_i == '0) ? win_t'(1) : window_i;
		end else begin
			case (state_q)
				WIN_COUNT: begin
					if (remain_q == win_t'(1)) begin
						state_d = WIN_DONE;
					end else begin
						remain_d = remain_q - 1'b1;
					end
				end
				WIN_DONE: state_d = WIN_DONE;   // hold counts
				default:  state_d = WIN_IDLE;
			endcase
		end
	end

	always_ff @(posedge dfx_upm_func_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q  <= WIN_IDLE;
			remain_q <= '0;
		end else begin
			state_q  <= state_d;
			remain_q <= remain_d;
		end
	end

	assign count_en_o = (state_q == WIN_COUNT);
	assign active_o   = (state_q == WIN_COUNT);
	assign done_o     = (state_q == WIN_DONE);

	a_en_done_excl: assert property (@(posedge dfx_upm_func_clk_i) disable iff (!arst_n_i)
		!(count_en_o && done_o))
		else $error("upm window: count_en and done together");

endmodule : upm_window_ctrl

`default_nettype wire

/* logic/upm_osc_counter.sv */
/*
 * upm oscillator counter: saturating tick count with sticky overflow
 */
`default_nettype none

module upm_osc_counter import upm_pkg::*; (
	input  wire logic dfx_upm_func_clk_i,
	input  wire logic arst_n_i,
	input  wire logic clear_i,
	input  wire logic tick_i,
	input  wire logic count_en_i,
	output      osc_cnt_t count_o,
	output      logic     ovf_o
);

	localparam osc_cnt_t CNT_MAX = '1;

	osc_cnt_t count_q;
	logic     ovf_q;

	always_ff @(posedge dfx_upm_func_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			count_q <= '0;
			ovf_q   <= 1'b0;
		end else if (clear_i) begin
			count_q <= '0;
			ovf_q   <= 1'b0;
		end else if (count_en_i && tick_i) begin
			if (count_q == CNT_MAX) begin
				ovf_q <= 1'b1;             // tick lost, hold at max
			end else begin
				count_q <= count_q + 1'b1;
			end
		end
	end

	assign count_o = count_q;
	assign ovf_o   = ovf_q;

	// no wrap, only clear brings the count down
	a_monotonic: assert property (@(posedge dfx_upm_func_clk_i) disable iff (!arst_n_i)
		!clear_i |=> count_o >= $past(count_o))
		else $error("upm counter: count decreased without clear");

endmodule : upm_osc_counter

`default_nettype wire

/* logic/upm_fabric.sv */
/*
 * upm monitor fabric: config chain, window control and the two
 * oscillator counters, assembles the result word
 */
`default_nettype none

module upm_fabric import upm_pkg::*; (
	input  wire logic       dfx_upm_func_clk_i,
	input  wire logic       arst_n_i,
	input  wire logic       sel_i,
	input  wire logic       capture_i,
	input  wire logic       shift_i,
	input  wire logic       update_i,
	input  wire logic       si_i,
	input  wire logic [1:0] tick_i,
	input  wire logic       pwr_err_i,
	output      logic       so_o,
	output      upm_cfg_t   cfg_o,
	output      logic       restart_o,
	output      logic       active_o
);

	upm_cfg_t    cfg;
	upm_result_t result;
	logic        start;
	logic        count_en;
	logic        done;
	logic        pwr_err_q;   // pwr_err as seen in the last window cycle
	osc_cnt_t    cnt [2];
	logic [1:0]  ovf;

	upm_cfg_chain u_chain (
		.dfx_upm_func_clk_i (dfx_upm_func_clk_i),
		.arst_n_i           (arst_n_i),
		.sel_i              (sel_i),
		.capture_i          (capture_i),
		.shift_i            (shift_i),
		.update_i           (update_i),
		.si_i               (si_i),
		.result_i           (result),
		.so_o               (so_o),
		.cfg_o              (cfg),
		.start_o            (start)
	);

	upm_window_ctrl u_win (
		.dfx_upm_func_clk_i (dfx_upm_func_clk_i),
		.arst_n_i           (arst_n_i),
		.start_i            (start),
		.window_i           (cfg.window),
		.count_en_o         (count_en),
		.active_o           (active_o),
		.done_o             (done)
	);

	// one counter per oscillator
	for (genvar k = 0; k < 2; k++) begin : g_osc
		upm_osc_counter u_cnt (
			.dfx_upm_func_clk_i (dfx_upm_func_clk_i),
			.arst_n_i           (arst_n_i),
			.clear_i            (start),
			.tick_i             (tick_i[k]),
			.count_en_i         (count_en),
			.count_o            (cnt[k]),
			.ovf_o              (ovf[k])
		);
	end

	// last load is the final window cycle, so it holds end-of-window value
	always_ff @(posedge dfx_upm_func_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pwr_err_q <= 1'b0;
		end else if (start) begin
			pwr_err_q <= 1'b0;
		end else if (count_en) begin
			pwr_err_q <= pwr_err_i;
		end
	end

	// --------------------
	// result word
	// --------------------
	always_comb begin
		result         = '0;
		result.done    = done;
		result.pwr_err = pwr_err_q;
		result.ovf     = ovf;
		result.cnt1    = cnt[1];
		result.cnt0    = cnt[0];
	end

	assign cfg_o     = cfg;
	assign restart_o = start;  // cbb dividers line up with the window

endmodule : upm_fabric

`default_nettype wire

/* logic/upm_cbb_wrapper.sv */
/*
 * upm cbb wrapper: model of the addressed cbb oscillators, power gated,
 * one tick pulse per period on the functional clock
 */
`default_nettype none

module upm_cbb_wrapper import upm_pkg::*; (
	input  wire logic       dfx_upm_func_clk_i,
	input  wire logic       arst_n_i,
	input  wire upm_cfg_t   cfg_i,
	input  wire logic       restart_i,
	output      logic [1:0] tick_o,
	output      logic       pwr_err_o
);

	logic pwr_on;   // addressed cbb powered

	// --------------------
	// power check
	// --------------------
	assign pwr_on    = cfg_i.pwr_en[cfg_i.addr];
	assign pwr_err_o = ~pwr_on;

	// --------------------
	// oscillators
	// --------------------
	for (genvar k = 0; k < 2; k++) begin : g_osc
		localparam int BASE = (k == 0) ? OSC0_BASE : OSC1_BASE;

		per_t period;    // (base + addr) * (div + 1)
		per_t pcnt_q;    // position in period 1..period

		assign period = (per_t'(BASE) + per_t'(cfg_i.addr)) * (per_t'(cfg_i.div) + 1'b1);

		always_ff @(posedge dfx_upm_func_clk_i or negedge arst_n_i) begin
			if (!arst_n_i) begin
				pcnt_q <= '0;
			end else if (restart_i) begin
				pcnt_q <= per_t'(1);           // first cycle after restart
			end else if (pcnt_q >= period) begin
				pcnt_q <= per_t'(1);           // wrap that also covers a period shrink
			end else if (pcnt_q != '0) begin
				pcnt_q <= pcnt_q + 1'b1;
			end
		end

		// pulse on every period-th cycle gated while unpowered
		assign tick_o[k] = (pcnt_q == period) & pwr_on;
	end

	a_no_tick_unpowered: assert property (@(posedge dfx_upm_func_clk_i) disable iff (!arst_n_i)
		pwr_err_o |-> (tick_o == 2'b00))
		else $error("upm cbb: tick while power enable is clear");

endmodule : upm_cbb_wrapper

`default_nettype wire

/* logic/upm_top.sv */
/*
 * upm top: monitor fabric plus cbb wrapper behind the scan chain
 */
`default_nettype none

module upm_top import upm_pkg::*; (
	input  wire logic       dfx_upm_func_clk_i,
	input  wire logic       arst_n_i,
	input  wire logic       dfx_upm_sel_i,
	input  wire logic       dfx_upm_capture_i,
	input  wire logic       dfx_upm_shift_i,
	input  wire logic       dfx_upm_update_i,
	input  wire logic       dfx_upm_si_i,
	output      logic       dfx_upm_so_o,
	output      logic       dfx_upm_active_o,
	output      logic [1:0] dfx_upm_dcm_o
);

	// --------------------
	// fabric <-> wrapper
	// --------------------
	upm_cfg_t   cfg;
	logic       restart;
	logic [1:0] tick;       // raw oscillator ticks
	logic       pwr_err;

	upm_fabric u_fabric (
		.dfx_upm_func_clk_i (dfx_upm_func_clk_i),
		.arst_n_i           (arst_n_i),
		.sel_i              (dfx_upm_sel_i),
		.capture_i          (dfx_upm_capture_i),
		.shift_i            (dfx_upm_shift_i),
		.update_i           (dfx_upm_update_i),
		.si_i               (dfx_upm_si_i),
		.tick_i             (tick),
		.pwr_err_i          (pwr_err),
		.so_o               (dfx_upm_so_o),
		.cfg_o              (cfg),
		.restart_o          (restart),
		.active_o           (dfx_upm_active_o)
	);

	upm_cbb_wrapper u_cbb (
		.dfx_upm_func_clk_i (dfx_upm_func_clk_i),
		.arst_n_i           (arst_n_i),
		.cfg_i              (cfg),
		.restart_i          (restart),
		.tick_o             (tick),
		.pwr_err_o          (pwr_err)
	);

	assign dfx_upm_dcm_o = tick;   // dcm observe, unregistered

endmodule : upm_top

`default_nettype wire

/* tests/upm_tb.sv */
/*
 * upm testbench: drives the scan chain from the vector file, runs each
 * measurement window and checks the captured result word
 */
`default_nettype none

module upm_tb import upm_pkg::*; ();

	localparam int          NUM_COLS   = 9;          // words per case in the vector file
	localparam int          MAX_CASES  = 32;
	localparam int          CASE_CHAIN = 8*CHAIN_W;  // upper bound on chain cycles per case
	localparam int          IDLE_WATCH = 16;         // cycles watched after a run-clear update
	localparam logic [31:0] LFSR_SEED  = 32'h9d87cf23;

	logic        clk;
	logic        arst_n;
	logic        sel;
	logic        capture;
	logic        shift;
	logic        update;
	logic        si;
	logic        so;
	logic        active;
	logic [1:0]  dcm;

	logic [31:0] vec_mem [0:NUM_COLS*MAX_CASES-1];
	logic [31:0] lfsr_q;          // idle gap source
	upm_result_t last_exp;        // previous expected result
	int          num_cases;
	int          wd_limit = 0;    // watchdog length in cycles
	int          val_errs = 0;
	int          other_errs = 0;

	upm_top upm_top_i (
		.dfx_upm_func_clk_i (clk),
		.arst_n_i           (arst_n),
		.dfx_upm_sel_i      (sel),
		.dfx_upm_capture_i  (capture),
		.dfx_upm_shift_i    (shift),
		.dfx_upm_update_i   (update),
		.dfx_upm_si_i       (si),
		.dfx_upm_so_o       (so),
		.dfx_upm_active_o   (active),
		.dfx_upm_dcm_o      (dcm)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog armed once the vectors are loaded
	initial begin
		wait (wd_limit > 0);
		repeat (wd_limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, run did not finish", wd_limit);
		$display("=== FAIL ===");
		$finish;
	end

	// --------------------
	// helpers
	// --------------------
	function automatic logic lfsr_bit();
		logic out;
		out    = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (out) begin
			lfsr_q = lfsr_q ^ 32'hd000_0001;  // taps 32 31 29 1
		end
		return out;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			val_errs++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("failure: %s at %0t", msg, $time);
		other_errs++;
	endtask

	// one clock of strobes driven by nba on the rising edge
	task automatic drive_strobes(input logic cap, input logic shf, input logic upd,
			input logic din);
		@(posedge clk);
		capture <= cap;
		shift   <= shf;
		update  <= upd;
		si      <= din;
	endtask

	// strobes low then 0..3 random extra cycles
	task automatic idle_gap();
		int n;
		n = 0;
		repeat (2) n = 2*n + int'(lfsr_bit());
		drive_strobes(1'b0, 1'b0, 1'b0, 1'b0);
		repeat (n) drive_strobes(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic shift_config(input upm_cfg_t cfg);
		logic [CHAIN_W-1:0] bits;
		bits = cfg;
		for (int i = 0; i < CHAIN_W; i++) begin
			drive_strobes(1'b0, 1'b1, 1'b0, bits[i]);   // lsb first
			if (lfsr_bit()) begin
				drive_strobes(1'b0, 1'b0, 1'b0, 1'b0);  // stall the shift
			end
		end
		idle_gap();
	endtask

	task automatic read_result(output upm_result_t res);
		logic [CHAIN_W-1:0] bits;
		drive_strobes(1'b1, 1'b0, 1'b0, 1'b0);
		idle_gap();
		@(negedge clk);
		bits[0] = so;
		for (int i = 1; i < CHAIN_W; i++) begin
			drive_strobes(1'b0, 1'b1, 1'b0, 1'b0);
			idle_gap();
			@(negedge clk);
			bits[i] = so;   // so is always the lsb
		end
		res = upm_result_t'(bits);
	endtask

	// k counts negedges from the update edge and active is expected for k in 1..weff
	task automatic watch_window(input win_t window, input logic gated);
		int k;
		int rise_k;
		int fall_k;
		int weff;
		weff   = (window == '0) ? 1 : int'(window);
		rise_k = -1;
		fall_k = -1;
		k      = 0;
		while (fall_k < 0 && k < weff + IDLE_WATCH) begin
			@(negedge clk);
			if (gated) begin
				check_value("dfx_upm_dcm_o", 64'(dcm), 64'd0);
			end
			if (active && rise_k < 0) begin
				rise_k = k;
			end else if (!active && rise_k >= 0) begin
				fall_k = k;
			end
			k++;
		end
		if (fall_k < 0) begin
			note_failure("dfx_upm_active_o did not complete its window in time");
		end else begin
			check_value("dfx_upm_active_o rise delay", 64'(rise_k), 64'd1);
			check_value("dfx_upm_active_o high cycles", 64'(fall_k - rise_k), 64'(weff));
		end
	endtask

	task automatic watch_idle();
		repeat (IDLE_WATCH) begin
			@(negedge clk);
			check_value("dfx_upm_active_o", 64'(active), 64'd0);
		end
	endtask

	// --------------------
	// one case per vector line
	// --------------------
	task automatic run_case(input int idx);
		upm_cfg_t    cfg;
		upm_result_t exp_res;
		upm_result_t res;
		int          base;
		base            = idx*NUM_COLS;
		cfg.run         = vec_mem[base][0];
		cfg.addr        = cbb_addr_t'(vec_mem[base+1]);
		cfg.div         = clk_div_t'(vec_mem[base+2]);
		cfg.pwr_en      = pwr_mask_t'(vec_mem[base+3]);
		cfg.window      = win_t'(vec_mem[base+4]);
		exp_res         = '0;
		exp_res.cnt0    = osc_cnt_t'(vec_mem[base+5]);
		exp_res.cnt1    = osc_cnt_t'(vec_mem[base+6]);
		exp_res.ovf     = vec_mem[base+7][1:0];
		exp_res.pwr_err = vec_mem[base+8][0];
		exp_res.done    = cfg.run | last_exp.done;   // done sticks after the first run

		shift_config(cfg);
		drive_strobes(1'b0, 1'b0, 1'b1, 1'b0);
		drive_strobes(1'b0, 1'b0, 1'b0, 1'b0);      // update sampled here
		if (cfg.run) begin
			watch_window(cfg.window, exp_res.pwr_err);
		end else begin
			watch_idle();
		end
		idle_gap();
		read_result(res);

		check_value("result.cnt0", 64'(res.cnt0), 64'(exp_res.cnt0));
		check_value("result.cnt1", 64'(res.cnt1), 64'(exp_res.cnt1));
		check_value("result.ovf", 64'(res.ovf), 64'(exp_res.ovf));
		check_value("result.pwr_err", 64'(res.pwr_err), 64'(exp_res.pwr_err));
		check_value("result.done", 64'(res.done), 64'(exp_res.done));
		check_value("result.pad", 64'(res.pad), 64'd0);
		if (!cfg.run) begin
			check_value("result word", 64'(res), 64'(last_exp));  // unchanged by config only
		end
		last_exp = exp_res;
	endtask

	initial begin
		int total;
		int w;
		arst_n   = 1'b0;
		sel      = 1'b0;
		capture  = 1'b0;
		shift    = 1'b0;
		update   = 1'b0;
		si       = 1'b0;
		lfsr_q   = LFSR_SEED;
		last_exp = '0;

		for (int i = 0; i < NUM_COLS*MAX_CASES; i++) begin
			vec_mem[i] = 32'hffff_ffff;   // end marker where the file stops
		end
		$readmemh("tests/upm_input.txt", vec_mem);
		num_cases = 0;
		while (num_cases < MAX_CASES && vec_mem[num_cases*NUM_COLS] != 32'hffff_ffff) begin
			num_cases++;
		end
		if (num_cases == 0) begin
			note_failure("no test vectors found in tests/upm_input.txt");
		end

		total = 20;   // reset and settle
		for (int c = 0; c < num_cases; c++) begin
			w     = int'(vec_mem[c*NUM_COLS+4]);
			total = total + ((w == 0) ? 1 : w) + IDLE_WATCH + CASE_CHAIN;
		end
		wd_limit = 2*total;

		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		sel    <= 1'b1;
		@(negedge clk);
		check_value("dfx_upm_active_o", 64'(active), 64'd0);   // reset state
		check_value("dfx_upm_dcm_o", 64'(dcm), 64'd0);
		check_value("dfx_upm_so_o", 64'(so), 64'd0);
		idle_gap();

		for (int c = 0; c < num_cases; c++) begin
			run_case(c);
		end

		$display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		if (val_errs + other_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule : upm_tb

`default_nettype wire

/* tests/upm_input.txt */
// columns: run addr div pwr_en window | expected cnt0 cnt1 ovf pwr_err (all hex)
// periods: osc0 (4+addr)*(div+1), osc1 (6+addr)*(div+1), count = window/period
1 0 0 ffff 0064  019 010 0 0
1 3 1 ffff 00c8  00e 00b 0 0
1 f 7 ffff 03e8  006 005 0 0
1 5 2 ffff 01f4  012 00f 0 0
// config only, result stays from the line above
0 1 0 0000 0040  012 00f 0 0
// cbb 6 unpowered
1 6 0 ffbf 012c  000 000 0 1
1 6 0 ffff 012c  01e 019 0 0
// zero window runs one cycle
1 0 0 ffff 0000  000 000 0 0
// osc0 saturates, osc1 below max
1 0 0 ffff 4e20  fff d05 1 0
// osc1 lands exactly on max
1 0 0 ffff 5ffa  fff fff 1 0
1 2 0 ffff 0025  006 004 0 0
1 9 4 ffff 0400  00f 00d 0 0

/* build.f */
logic/upm_pkg.sv
logic/upm_cfg_chain.sv
logic/upm_window_ctrl.sv
logic/upm_osc_counter.sv
logic/upm_fabric.sv
logic/upm_cbb_wrapper.sv
logic/upm_top.sv
tests/upm_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := upm_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
VECTORS   := tests/upm_input.txt
FAIL_MSG  := === FAIL ===

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(VECTORS)
	@./$(SIM_BIN) > $(SIM_LOG) 2>&1; status=$$?; cat $(SIM_LOG); \
	if [ $$status -ne 0 ] || grep -q '$(FAIL_MSG)' $(SIM_LOG); then \
		echo "simulation failed, see $(SIM_LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
